// ==== include/edge_cfg.svh ====
`ifndef EDGE_CFG_SVH
`define EDGE_CFG_SVH

// --------------------------------------------------
// Video stream geometry
// --------------------------------------------------
`define EDGE_PIX_W      8    // Grey pixel width
`define EDGE_MAX_HDISP  64   // Line buffer depth, longest line handled

// --------------------------------------------------
// AXI4-Lite register map
// --------------------------------------------------
`define EDGE_ADDR_W     4    // Byte address width

`define EDGE_REG_CTRL   4'h0 // Bit 0 enable, bit 1 kernel mode
`define EDGE_REG_THRESH 4'h4 // Gradient threshold, bits 7:0
`define EDGE_REG_COUNT  4'h8 // Edge pixels in last frame, read only

`endif

// ==== src/edge_pkg.sv ====
package edge_pkg;

    // --------------------------------------------------
    // Gradient kernel selection
    // --------------------------------------------------
    // Sobel weights the centre row/column by 2,
    // Prewitt keeps every weight at 1
    typedef enum logic {
        KERNEL_SOBEL   = 1'b0,
        KERNEL_PREWITT = 1'b1
    } kernel_e;

    // --------------------------------------------------
    // Register index, taken from byte address bits 3:2
    // --------------------------------------------------
    typedef enum logic [1:0] {
        IDX_CTRL   = 2'd0,  // 0x0
        IDX_THRESH = 2'd1,  // 0x4
        IDX_COUNT  = 2'd2   // 0x8
    } reg_idx_e;

    // Index 3 is unmapped and reads as zero

endpackage

// ==== src/edge_regs.sv ====
`timescale 1ns/10ps
`include "edge_cfg.svh"

module edge_regs (
    input  logic                    clk,
    input  logic                    rst_n,
    // AXI4-Lite write channels
    input  logic [`EDGE_ADDR_W-1:0] awaddr,
    input  logic                    awvalid,
    output logic                    awready,
    input  logic [31:0]             wdata,
    input  logic [3:0]              wstrb,
    input  logic                    wvalid,
    output logic                    wready,
    output logic [1:0]              bresp,
    output logic                    bvalid,
    input  logic                    bready,
    // AXI4-Lite read channels
    input  logic [`EDGE_ADDR_W-1:0] araddr,
    input  logic                    arvalid,
    output logic                    arready,
    output logic [31:0]             rdata,
    output logic [1:0]              rresp,
    output logic                    rvalid,
    input  logic                    rready,
    // Processed stream fed back for edge counting
    input  logic                    post_vs,
    input  logic                    post_de,
    input  logic                    post_bit,
    // Control fields to the gradient stage
    output logic                    enable,
    output edge_pkg::kernel_e       mode,
    output logic [7:0]              threshold
);

    logic               wr_go;      // AW and W accepted together
    logic               rd_go;      // AR accepted
    edge_pkg::reg_idx_e wr_idx;
    edge_pkg::reg_idx_e rd_idx;
    logic [31:0]        rd_word;    // Read mux result
    logic               post_vs_q;  // For rising edge of post_vs
    logic [31:0]        edge_run;   // Running count, current frame
    logic [31:0]        edge_count; // Latched count, last frame

    // --------------------------------------------------
    // Handshakes
    // --------------------------------------------------
    // Both write channels must be present, and the B slot free
    assign wr_go   = awvalid & wvalid & ~bvalid;
    assign awready = wr_go;
    assign wready  = wr_go;
    assign arready = arvalid & ~rvalid;   // One read outstanding at most
    assign rd_go   = arready;

    assign bresp = 2'b00;   // Always OKAY
    assign rresp = 2'b00;

    assign wr_idx = edge_pkg::reg_idx_e'(awaddr[3:2]);
    assign rd_idx = edge_pkg::reg_idx_e'(araddr[3:2]);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bvalid <= 1'b0;
        end else if (wr_go) begin
            bvalid <= 1'b1;
        end else if (bready) begin
            bvalid <= 1'b0;   // Response taken
        end
    end

    // --------------------------------------------------
    // Control and threshold registers
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            enable    <= 1'b0;
            mode      <= edge_pkg::KERNEL_SOBEL;
            threshold <= 8'd0;
        end else if (wr_go && wstrb[0]) begin   // All fields live in byte 0
            case (wr_idx)
                edge_pkg::IDX_CTRL: begin
                    enable <= wdata[0];
                    mode   <= edge_pkg::kernel_e'(wdata[1]);
                end
                edge_pkg::IDX_THRESH: threshold <= wdata[7:0];
                default: ;                      // COUNT and holes ignore writes
            endcase
        end
    end

    // --------------------------------------------------
    // Read path
    // --------------------------------------------------
    always_comb begin
        case (rd_idx)
            edge_pkg::IDX_CTRL:   rd_word = {30'd0, mode, enable};
            edge_pkg::IDX_THRESH: rd_word = {24'd0, threshold};
            edge_pkg::IDX_COUNT:  rd_word = edge_count;
            default:              rd_word = 32'd0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rvalid <= 1'b0;
        end else if (rd_go) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    // Data held while rvalid waits for rready
    always_ff @(posedge clk) begin
        if (rd_go) rdata <= rd_word;
    end

    // --------------------------------------------------
    // Edge pixel counter
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            post_vs_q  <= 1'b0;
            edge_run   <= 32'd0;
            edge_count <= 32'd0;
        end else begin
            post_vs_q <= post_vs;
            if (post_vs && !post_vs_q) begin    // Frame boundary on output side
                edge_count <= edge_run;
                edge_run   <= 32'd0;
            end else if (post_de && post_bit) begin
                edge_run <= edge_run + 32'd1;
            end
        end
    end

endmodule

// ==== src/line_window.sv ====
`timescale 1ns/10ps
`include "edge_cfg.svh"

module line_window (
    input  logic                   clk,
    input  logic                   rst_n,
    // Incoming grey stream
    input  logic                   pre_vs,
    input  logic                   pre_de,
    input  logic [`EDGE_PIX_W-1:0] pre_data,
    // 3x3 neighbourhood, one cycle behind the input
    output logic                   win_vs,
    output logic                   win_de,
    output logic [`EDGE_PIX_W-1:0] p11,
    output logic [`EDGE_PIX_W-1:0] p12,
    output logic [`EDGE_PIX_W-1:0] p13,
    output logic [`EDGE_PIX_W-1:0] p21,
    output logic [`EDGE_PIX_W-1:0] p22,
    output logic [`EDGE_PIX_W-1:0] p23,
    output logic [`EDGE_PIX_W-1:0] p31,
    output logic [`EDGE_PIX_W-1:0] p32,
    output logic [`EDGE_PIX_W-1:0] p33
);

    // Line buffers, line1 one line back, line2 two lines back
    logic [`EDGE_PIX_W-1:0] line1 [`EDGE_MAX_HDISP];
    logic [`EDGE_PIX_W-1:0] line2 [`EDGE_MAX_HDISP];

    logic [$clog2(`EDGE_MAX_HDISP)-1:0] col_q;    // Next column
    logic [$clog2(`EDGE_MAX_HDISP)-1:0] col_addr; // Column of current pixel
    logic                               line_start;
    logic [`EDGE_PIX_W-1:0]             up1;      // Pixel above, same column
    logic [`EDGE_PIX_W-1:0]             up2;      // Two lines above

    // --------------------------------------------------
    // Column counter
    // --------------------------------------------------
    // win_de is pre_de one cycle late, so it doubles as the edge detector
    assign line_start = pre_de & ~win_de;
    assign col_addr   = line_start ? '0 : col_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            col_q <= '0;
        end else if (pre_de) begin
            if (32'(col_addr) == `EDGE_MAX_HDISP - 1) begin
                col_q <= col_addr;              // Saturate at last entry
            end else begin
                col_q <= col_addr + 1'b1;
            end
        end
    end

    // --------------------------------------------------
    // Line buffers
    // --------------------------------------------------
    assign up1 = line1[col_addr];
    assign up2 = line2[col_addr];

    always_ff @(posedge clk) begin
        if (pre_vs) begin
            // Blanking wipes history so row 1 sees zero above it
            for (int i = 0; i < `EDGE_MAX_HDISP; i++) begin
                line1[i] <= '0;
                line2[i] <= '0;
            end
        end else if (pre_de) begin
            line2[col_addr] <= up1;         // Cascade older line down
            line1[col_addr] <= pre_data;
        end
    end

    // --------------------------------------------------
    // Tap shift registers
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (pre_de) begin
            p13 <= up2;                     // Right column is the new pixel
            p23 <= up1;
            p33 <= pre_data;
            p12 <= line_start ? '0 : p13;   // Nothing left of the line start
            p22 <= line_start ? '0 : p23;
            p32 <= line_start ? '0 : p33;
            p11 <= line_start ? '0 : p12;
            p21 <= line_start ? '0 : p22;
            p31 <= line_start ? '0 : p32;
        end
    end

    // Frame and line timing, one stage
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            win_vs <= 1'b0;
            win_de <= 1'b0;
        end else begin
            win_vs <= pre_vs;
            win_de <= pre_de;
        end
    end

endmodule

// ==== src/edge_gradient.sv ====
`timescale 1ns/10ps
`include "edge_cfg.svh"

module edge_gradient (
    input  logic                   clk,
    input  logic                   rst_n,
    // Control from the register block
    input  logic                   enable,
    input  edge_pkg::kernel_e      mode,
    input  logic [7:0]             threshold,
    // Window from the line buffers
    input  logic                   win_vs,
    input  logic                   win_de,
    input  logic [`EDGE_PIX_W-1:0] p11,
    input  logic [`EDGE_PIX_W-1:0] p12,
    input  logic [`EDGE_PIX_W-1:0] p13,
    input  logic [`EDGE_PIX_W-1:0] p21,
    input  logic [`EDGE_PIX_W-1:0] p22,
    input  logic [`EDGE_PIX_W-1:0] p23,
    input  logic [`EDGE_PIX_W-1:0] p31,
    input  logic [`EDGE_PIX_W-1:0] p32,
    input  logic [`EDGE_PIX_W-1:0] p33,
    // Edge bit stream
    output logic                   post_vs,
    output logic                   post_de,
    output logic                   post_bit
);

    //        Gx                 Gy
    //  [ -1   0  +1 ]    [ +1  +w  +1 ]
    //  [ -w   0  +w ]    [  0   0   0 ]
    //  [ -1   0  +1 ]    [ -1  -w  -1 ]
    // w = 2 for Sobel, 1 for Prewitt; p22 never contributes

    // One side of a kernel, outer taps weight 1, middle tap weight w
    function automatic logic [`EDGE_PIX_W+1:0] side_sum(
        input logic [`EDGE_PIX_W-1:0] a,
        input logic [`EDGE_PIX_W-1:0] mid,
        input logic [`EDGE_PIX_W-1:0] c,
        input logic                   dbl
    );
        logic [`EDGE_PIX_W+1:0] mid_w;
        mid_w = dbl ? {1'b0, mid, 1'b0} : {2'b00, mid};
        return {2'b00, a} + {2'b00, c} + mid_w;
    endfunction

    logic                   sobel;
    logic [`EDGE_PIX_W+1:0] gx_pos, gx_neg;  // Stage 1
    logic [`EDGE_PIX_W+1:0] gy_pos, gy_neg;
    logic [`EDGE_PIX_W+1:0] gx_abs, gy_abs;  // Stage 2
    logic [31:0]            sq_sum;          // Stage 3
    logic [31:0]            thr_sq;
    logic [3:0]             vs_pipe;         // Timing delay line
    logic [3:0]             de_pipe;

    assign sobel = (mode == edge_pkg::KERNEL_SOBEL);

    // --------------------------------------------------
    // Stage 1, weighted partial sums
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        gx_pos <= side_sum(p13, p23, p33, sobel);   // Right column
        gx_neg <= side_sum(p11, p21, p31, sobel);   // Left column
        gy_pos <= side_sum(p11, p12, p13, sobel);   // Top row
        gy_neg <= side_sum(p31, p32, p33, sobel);   // Bottom row
    end

    // --------------------------------------------------
    // Stage 2, absolute gradients
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        gx_abs <= (gx_pos >= gx_neg) ? gx_pos - gx_neg : gx_neg - gx_pos;
        gy_abs <= (gy_pos >= gy_neg) ? gy_pos - gy_neg : gy_neg - gy_pos;
    end

    // --------------------------------------------------
    // Stage 3, squared magnitude
    // --------------------------------------------------
    // Sum of squares replaces the square root, compared against thr^2
    always_ff @(posedge clk) begin
        sq_sum <= 32'(gx_abs) * 32'(gx_abs) + 32'(gy_abs) * 32'(gy_abs);
    end

    // --------------------------------------------------
    // Stage 4, threshold and gate
    // --------------------------------------------------
    assign thr_sq = 32'(threshold) * 32'(threshold);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            post_bit <= 1'b0;
        end else begin
            // de_pipe[2] travels with sq_sum, so blanking never flags an edge
            post_bit <= enable & de_pipe[2] & (sq_sum >= thr_sq);
        end
    end

    // vs/de follow the four data stages
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vs_pipe <= 4'd0;
            de_pipe <= 4'd0;
        end else begin
            vs_pipe <= {vs_pipe[2:0], win_vs};
            de_pipe <= {de_pipe[2:0], win_de};
        end
    end

    assign post_vs = vs_pipe[3];
    assign post_de = de_pipe[3];

endmodule

// ==== src/edge_top.sv ====
`timescale 1ns/10ps
`include "edge_cfg.svh"

module edge_top (
    input  logic                    clk,
    input  logic                    rst_n,
    // AXI4-Lite slave
    input  logic [`EDGE_ADDR_W-1:0] awaddr,
    input  logic                    awvalid,
    output logic                    awready,
    input  logic [31:0]             wdata,
    input  logic [3:0]              wstrb,
    input  logic                    wvalid,
    output logic                    wready,
    output logic [1:0]              bresp,
    output logic                    bvalid,
    input  logic                    bready,
    input  logic [`EDGE_ADDR_W-1:0] araddr,
    input  logic                    arvalid,
    output logic                    arready,
    output logic [31:0]             rdata,
    output logic [1:0]              rresp,
    output logic                    rvalid,
    input  logic                    rready,
    // Video in
    input  logic                    pre_vs,
    input  logic                    pre_de,
    input  logic [`EDGE_PIX_W-1:0]  pre_data,
    // Edge map out, 5 cycles behind pre
    output logic                    post_vs,
    output logic                    post_de,
    output logic                    post_bit
);

    logic                   enable;
    edge_pkg::kernel_e      mode;
    logic [7:0]             threshold;
    logic                   win_vs, win_de;
    logic [`EDGE_PIX_W-1:0] p11, p12, p13;
    logic [`EDGE_PIX_W-1:0] p21, p22, p23;
    logic [`EDGE_PIX_W-1:0] p31, p32, p33;

    // --------------------------------------------------
    // Register block, also counts edges on the output
    // --------------------------------------------------
    edge_regs u_regs (
        .clk      (clk),      .rst_n    (rst_n),
        .awaddr   (awaddr),   .awvalid  (awvalid),  .awready  (awready),
        .wdata    (wdata),    .wstrb    (wstrb),    .wvalid   (wvalid),
        .wready   (wready),   .bresp    (bresp),    .bvalid   (bvalid),
        .bready   (bready),   .araddr   (araddr),   .arvalid  (arvalid),
        .arready  (arready),  .rdata    (rdata),    .rresp    (rresp),
        .rvalid   (rvalid),   .rready   (rready),
        .post_vs  (post_vs),  .post_de  (post_de),  .post_bit (post_bit),
        .enable   (enable),   .mode     (mode),     .threshold(threshold)
    );

    // 3x3 window, 1 cycle
    line_window u_window (
        .clk     (clk),     .rst_n  (rst_n),
        .pre_vs  (pre_vs),  .pre_de (pre_de),  .pre_data (pre_data),
        .win_vs  (win_vs),  .win_de (win_de),
        .p11 (p11), .p12 (p12), .p13 (p13),
        .p21 (p21), .p22 (p22), .p23 (p23),
        .p31 (p31), .p32 (p32), .p33 (p33)
    );

    // Gradient and threshold, 4 cycles
    edge_gradient u_gradient (
        .clk      (clk),      .rst_n  (rst_n),
        .enable   (enable),   .mode   (mode),   .threshold (threshold),
        .win_vs   (win_vs),   .win_de (win_de),
        .p11 (p11), .p12 (p12), .p13 (p13),
        .p21 (p21), .p22 (p22), .p23 (p23),
        .p31 (p31), .p32 (p32), .p33 (p33),
        .post_vs  (post_vs),  .post_de (post_de), .post_bit (post_bit)
    );

endmodule

// ==== sim/edge_props.sv ====
`timescale 1ns/10ps

module edge_props (
    input logic        clk,
    input logic        rst_n,
    input logic        awready,
    input logic        wready,
    input logic [1:0]  bresp,
    input logic        bvalid,
    input logic        bready,
    input logic        arready,
    input logic [31:0] rdata,
    input logic [1:0]  rresp,
    input logic        rvalid,
    input logic        rready,
    input logic        pre_vs,
    input logic        pre_de,
    input logic        post_vs,
    input logic        post_de,
    input logic        post_bit
);

    // --------------------------------------------------
    // Reset state
    // --------------------------------------------------
    reset_quiet: assert property (@(posedge clk)
        !rst_n |-> !post_vs && !post_de && !post_bit && !bvalid && !rvalid)
        else $error("Outputs or responses active during reset");

    reset_no_ready: assert property (@(posedge clk) !rst_n |-> !awready && !arready)
        else $error("Ready raised during reset without a request");

    // --------------------------------------------------
    // Stream timing, window 1 cycle plus gradient 4
    // --------------------------------------------------
    de_delay: assert property (@(posedge clk) disable iff (!rst_n)
        post_de == $past(pre_de, 5))
        else $error("post_de is not pre_de delayed by 5 cycles");

    vs_delay: assert property (@(posedge clk) disable iff (!rst_n)
        post_vs == $past(pre_vs, 5))
        else $error("post_vs is not pre_vs delayed by 5 cycles");

    bit_in_de: assert property (@(posedge clk) disable iff (!rst_n) post_bit |-> post_de)
        else $error("post_bit set outside active pixels");

    // --------------------------------------------------
    // AXI responses held under back-pressure
    // --------------------------------------------------
    b_hold: assert property (@(posedge clk) disable iff (!rst_n)
        bvalid && !bready |=> bvalid && $stable(bresp))
        else $error("Write response dropped or changed before bready");

    r_hold: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
        else $error("Read data dropped or changed before rready");

    aw_block: assert property (@(posedge clk) disable iff (!rst_n)
        bvalid |-> !awready && !wready)   // One write in flight
        else $error("Write accepted while a response is pending");

    ar_block: assert property (@(posedge clk) disable iff (!rst_n) rvalid |-> !arready)
        else $error("Read accepted while read data is pending");

endmodule

bind edge_top edge_props u_props (
    .clk      (clk),      .rst_n    (rst_n),
    .awready  (awready),  .wready   (wready),   .bresp   (bresp),
    .bvalid   (bvalid),   .bready   (bready),   .arready (arready),
    .rdata    (rdata),    .rresp    (rresp),    .rvalid  (rvalid),
    .rready   (rready),   .pre_vs   (pre_vs),   .pre_de  (pre_de),
    .post_vs  (post_vs),  .post_de  (post_de),  .post_bit(post_bit)
);

// ==== sim/edge_tb.sv ====
`timescale 1ns/10ps
`include "edge_cfg.svh"

module edge_tb;

    localparam int frame_w      = 16;
    localparam int frame_h      = 8;
    localparam int frame_cycles = 4 + frame_h * (frame_w + 3) + 6;  // vs, lines, drain
    localparam int frame_count  = 9;
    localparam int axi_cycles   = 300;
    localparam int watchdog_ns  = 2 * (frame_count * frame_cycles + axi_cycles) * 8;

    logic                    clk;
    logic                    rst_n;
    logic [`EDGE_ADDR_W-1:0] awaddr;
    logic                    awvalid;
    logic                    awready;
    logic [31:0]             wdata;
    logic [3:0]              wstrb;
    logic                    wvalid;
    logic                    wready;
    logic [1:0]              bresp;
    logic                    bvalid;
    logic                    bready;
    logic [`EDGE_ADDR_W-1:0] araddr;
    logic                    arvalid;
    logic                    arready;
    logic [31:0]             rdata;
    logic [1:0]              rresp;
    logic                    rvalid;
    logic                    rready;
    logic                    pre_vs;
    logic                    pre_de;
    logic [`EDGE_PIX_W-1:0]  pre_data;
    logic                    post_vs;
    logic                    post_de;
    logic                    post_bit;

    logic [15:0]            lfsr_state;
    logic [`EDGE_PIX_W-1:0] frame [frame_h][frame_w];  // Model copy of current frame
    logic                   exp_q [$];                 // Expected edge bits in order
    int                     pos_q [$];                 // Matching row * width + col
    logic                   sh_enable;                 // Shadow of programmed fields
    logic                   sh_sobel;
    logic [7:0]             sh_thresh;
    int                     frame_kind;                // 0 random, 1 flat, 2 step
    int                     frame_edges;
    int                     prev_edges;
    logic                   chk_bit;
    int                     chk_pos;
    int                     chk_row;
    int                     chk_col;
    logic                   pattern_bit;

    edge_top u_edge_top (
        .clk     (clk),     .rst_n   (rst_n),
        .awaddr  (awaddr),  .awvalid (awvalid), .awready (awready),
        .wdata   (wdata),   .wstrb   (wstrb),   .wvalid  (wvalid),
        .wready  (wready),  .bresp   (bresp),   .bvalid  (bvalid),
        .bready  (bready),  .araddr  (araddr),  .arvalid (arvalid),
        .arready (arready), .rdata   (rdata),   .rresp   (rresp),
        .rvalid  (rvalid),  .rready  (rready),
        .pre_vs  (pre_vs),  .pre_de  (pre_de),  .pre_data(pre_data),
        .post_vs (post_vs), .post_de (post_de), .post_bit(post_bit)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;   // 8 ns period

    // --------------------------------------------------
    // Helpers
    // --------------------------------------------------
    // Galois LFSR with taps x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic draw_pixel(output logic [`EDGE_PIX_W-1:0] px);
        for (int i = 0; i < `EDGE_PIX_W; i++) begin
            px[i]      = lfsr_state[0];         // One step per bit
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // Model frame pixel that reads zero above and left of the frame
    function automatic int tap(input int r, input int c);
        if (r < 0 || c < 0) return 0;
        return int'(frame[r[2:0]][c[3:0]]);
    endfunction

    // Window ending at (r, c) with the current line as its bottom row
    function automatic logic model_bit(input int r, input int c);
        int w;
        int gx;
        int gy;
        w  = sh_sobel ? 2 : 1;
        gx = tap(r - 2, c) + w * tap(r - 1, c) + tap(r, c)
           - tap(r - 2, c - 2) - w * tap(r - 1, c - 2) - tap(r, c - 2);
        gy = tap(r - 2, c - 2) + w * tap(r - 2, c - 1) + tap(r - 2, c)
           - tap(r, c - 2) - w * tap(r, c - 1) - tap(r, c);
        return sh_enable && (gx * gx + gy * gy >= int'(sh_thresh) * int'(sh_thresh));
    endfunction

    task automatic abort_run();
        $display("Simulation failed");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;                 // Inputs change just after the edge
    endtask

    // --------------------------------------------------
    // AXI4-Lite master
    // --------------------------------------------------
    task automatic axi_write(input logic [`EDGE_ADDR_W-1:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, input int hold);
        awaddr  = addr;
        wdata   = data;
        wstrb   = strb;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        @(negedge clk);
        while (!(awready && wready)) @(negedge clk);
        next_cycle();                   // Both channels taken on this edge
        repeat (hold) next_cycle();     // Valids stay up while the pending response blocks them
        awvalid = 1'b0;
        wvalid  = 1'b0;
        bready = 1'b1;
        @(negedge clk);
        while (!bvalid) @(negedge clk);
        assert (bresp == 2'b00) else begin
            $display("FAIL bresp expected 0x0 got 0x%0h", bresp);
            abort_run();
        end
        next_cycle();
        bready = 1'b0;
    endtask

    task automatic axi_read(input logic [`EDGE_ADDR_W-1:0] addr, input int hold,
                            output logic [31:0] data);
        araddr  = addr;
        arvalid = 1'b1;
        @(negedge clk);
        while (!arready) @(negedge clk);
        next_cycle();
        repeat (hold) next_cycle();     // arvalid stays up while rvalid waits for rready
        arvalid = 1'b0;
        rready = 1'b1;
        @(negedge clk);
        while (!rvalid) @(negedge clk);
        assert (rresp == 2'b00) else begin
            $display("FAIL rresp expected 0x0 got 0x%0h", rresp);
            abort_run();
        end
        data = rdata;
        next_cycle();
        rready = 1'b0;
    endtask

    task automatic check_read(input logic [`EDGE_ADDR_W-1:0] addr, input logic [31:0] expected,
                              input string name);
        logic [31:0] got;
        axi_read(addr, 2, got);
        assert (got == expected) else begin
            $display("FAIL %s expected 0x%08h got 0x%08h", name, expected, got);
            abort_run();
        end
    endtask

    task automatic configure(input logic en, input edge_pkg::kernel_e mode,
                             input logic [7:0] thr);
        axi_write(`EDGE_REG_CTRL, {30'd0, mode, en}, 4'h1, 1);
        axi_write(`EDGE_REG_THRESH, {24'd0, thr}, 4'h1, 0);
        sh_enable = en;
        sh_sobel  = (mode == edge_pkg::KERNEL_SOBEL);
        sh_thresh = thr;
    endtask

    // --------------------------------------------------
    // Frame stimulus and reference
    // --------------------------------------------------
    task automatic run_frame(input int kind);
        logic [`EDGE_PIX_W-1:0] px;
        logic                   exp_now;
        frame_kind  = kind;
        frame_edges = 0;
        for (int r = 0; r < frame_h; r++) begin
            for (int c = 0; c < frame_w; c++) begin
                case (kind)
                    0:       draw_pixel(px);
                    1:       px = 8'd120;                              // Flat grey
                    default: px = (c < frame_w / 2) ? 8'd20 : 8'd120;  // Step of 100
                endcase
                frame[r[2:0]][c[3:0]] = px;
            end
        end
        pre_vs = 1'b1;
        repeat (4) next_cycle();
        pre_vs = 1'b0;
        for (int r = 0; r < frame_h; r++) begin
            for (int c = 0; c < frame_w; c++) begin
                pre_de   = 1'b1;
                pre_data = frame[r[2:0]][c[3:0]];
                exp_now  = model_bit(r, c);
                exp_q.push_back(exp_now);
                pos_q.push_back(r * frame_w + c);
                if (exp_now) frame_edges++;
                next_cycle();
            end
            pre_de = 1'b0;
            repeat (3) next_cycle();    // Line blanking
        end
        repeat (6) next_cycle();        // Pipeline drain
        assert (exp_q.size() == 0) else begin
            $display("Frame ended with %0d pixels never shown on post_de", exp_q.size());
            abort_run();
        end
    endtask

    // COUNT is latched at this frame's post_vs, so it holds the frame before
    task automatic run_and_count(input int kind);
        run_frame(kind);
        check_read(`EDGE_REG_COUNT, 32'(prev_edges), "rdata COUNT");
        prev_edges = frame_edges;
    endtask

    // --------------------------------------------------
    // Scoreboard
    // --------------------------------------------------
    always @(negedge clk) begin
        if (rst_n && post_de) begin
            if (exp_q.size() == 0) begin
                $display("post_de high with no pixel expected");
                abort_run();
            end else begin
                chk_bit = exp_q.pop_front();
                chk_pos = pos_q.pop_front();
                chk_row = chk_pos / frame_w;
                chk_col = chk_pos % frame_w;
                assert (post_bit == chk_bit) else begin
                    $display("FAIL post_bit row %0d col %0d expected 0x%0h got 0x%0h",
                             chk_row, chk_col, chk_bit, post_bit);
                    abort_run();
                end
                // Fixed patterns have interior edges only across the step
                pattern_bit = (frame_kind == 2) &&
                              (chk_col == frame_w / 2 || chk_col == frame_w / 2 + 1);
                if (frame_kind != 0 && chk_row >= 2 && chk_col >= 2) begin
                    assert (post_bit == pattern_bit) else begin
                        $display("FAIL post_bit pattern row %0d col %0d expected 0x%0h got 0x%0h",
                                 chk_row, chk_col, pattern_bit, post_bit);
                        abort_run();
                    end
                end
            end
        end
    end

    initial begin
        #(watchdog_ns);
        $display("Watchdog expired before the test sequence finished");
        abort_run();
    end

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------
    initial begin
        rst_n      = 1'b0;
        awaddr     = '0;
        awvalid    = 1'b0;
        wdata      = 32'd0;
        wstrb      = 4'h0;
        wvalid     = 1'b0;
        bready     = 1'b0;
        araddr     = '0;
        arvalid    = 1'b0;
        rready     = 1'b0;
        pre_vs     = 1'b0;
        pre_de     = 1'b0;
        pre_data   = '0;
        lfsr_state = 16'd49;
        sh_enable  = 1'b0;
        sh_sobel   = 1'b1;
        sh_thresh  = 8'd0;
        frame_kind = 0;
        prev_edges = 0;
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        next_cycle();

        // Register map
        axi_write(`EDGE_REG_CTRL, 32'h3, 4'hF, 2);
        check_read(`EDGE_REG_CTRL, 32'h3, "rdata CTRL");
        axi_write(`EDGE_REG_THRESH, 32'hA5, 4'hF, 0);
        check_read(`EDGE_REG_THRESH, 32'hA5, "rdata THRESH");
        axi_write(`EDGE_REG_THRESH, 32'h11, 4'h0, 0);   // No byte lanes enabled so nothing changes
        check_read(`EDGE_REG_THRESH, 32'hA5, "rdata THRESH");
        axi_write(`EDGE_REG_COUNT, 32'h1234, 4'hF, 1);  // Read only
        check_read(`EDGE_REG_COUNT, 32'h0, "rdata COUNT");
        check_read(4'hC, 32'h0, "rdata unused");

        // Random frames in both kernels
        configure(1'b1, edge_pkg::KERNEL_SOBEL, 8'd200);
        run_and_count(0);
        run_and_count(0);
        configure(1'b1, edge_pkg::KERNEL_PREWITT, 8'd150);
        run_and_count(0);
        run_and_count(0);

        // Flat and step patterns
        configure(1'b1, edge_pkg::KERNEL_SOBEL, 8'd50);
        run_and_count(1);
        run_and_count(2);
        configure(1'b1, edge_pkg::KERNEL_PREWITT, 8'd50);
        run_and_count(2);

        // With the detector off the next COUNT reads zero
        configure(1'b0, edge_pkg::KERNEL_SOBEL, 8'd10);
        run_and_count(0);
        configure(1'b1, edge_pkg::KERNEL_SOBEL, 8'd200);
        run_and_count(0);

        $display("Simulation passed");
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+include
src/edge_pkg.sv
src/edge_regs.sv
src/line_window.sv
src/edge_gradient.sv
src/edge_top.sv
sim/edge_props.sv
sim/edge_tb.sv

// ==== Makefile ====
BIN := obj_dir/Vedge_tb

.PHONY: run clean

# Pass only when the testbench prints its pass line
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "Simulation passed"

# Rebuilt only when a source, header or the file list changes
$(BIN): all.f $(wildcard src/*.sv sim/*.sv include/*.svh)
	verilator --binary --assert --top-module edge_tb -f all.f -Mdir obj_dir

clean:
	rm -rf obj_dir
